// File: hw/trap_pkg.sv
// Shared widths, CSR address encoding and constants for the trap unit RTL and its testbench.
package trap_pkg;

    // Data path width of every CSR.
    localparam int XLEN = 32;
    // CSR address width.
    localparam int CSR_ADDR_W = 12;

    // Stored mcause number width.
    localparam int CAUSE_W = 5;
    // Synchronous trap cause as delivered by the pipeline.
    localparam int TRAP_CAUSE_W = 4;

    // External interrupt lines occupy numbers 16 to 31.
    localparam int IRQ_LO = 16;
    localparam int IRQ_HI = 31;

    // Cycles mstatus.mie must already have been set before interrupts fire.
    localparam int MIE_DELAY = 2;

    // RV32 with I and M extensions.
    localparam logic [XLEN-1:0] MISA_VALUE = 32'h4000_1100;
    // Single hart system.
    localparam logic [XLEN-1:0] HART_ID = 32'h0000_0000;

    // Field positions inside mstatus.
    localparam int MSTATUS_MIE_BIT = 3;
    localparam int MSTATUS_MPIE_BIT = 7;

    // Implemented machine CSRs, used as the opcodes of the CSR port.
    typedef enum logic [CSR_ADDR_W-1:0] {
        CSR_MSTATUS    = 12'h300,
        CSR_MISA       = 12'h301,
        CSR_MEDELEG    = 12'h302,
        CSR_MIDELEG    = 12'h303,
        CSR_MIE        = 12'h304,
        CSR_MTVEC      = 12'h305,
        CSR_MSTATUSH   = 12'h310,
        CSR_MSCRATCH   = 12'h340,
        CSR_MEPC       = 12'h341,
        CSR_MCAUSE     = 12'h342,
        CSR_MTVAL      = 12'h343,
        CSR_MIP        = 12'h344,
        CSR_MVENDORID  = 12'hf11,
        CSR_MARCHID    = 12'hf12,
        CSR_MIMPID     = 12'hf13,
        CSR_MHARTID    = 12'hf14,
        CSR_MCONFIGPTR = 12'hf15
    } csr_addr_e;

endpackage

// File: hw/csr_file.sv
// Machine-mode CSR storage with combinational read decode and trap, write and mret updates.
`timescale 1ns/10ps

module csr_file import trap_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,

    // CSR access port.
    input  csr_addr_e            csr_addr,
    input  logic                 csr_we,
    input  logic [XLEN-1:0]      csr_wdata,
    output logic [XLEN-1:0]      csr_rdata,
    output logic                 csr_exists,
    output logic                 csr_rdonly,

    // Trap entry from the dispatcher.
    input  logic                 ex_take,
    input  logic                 ex_irq,
    input  logic [CAUSE_W-1:0]   ex_cause,
    input  logic [XLEN-1:1]      ex_epc,

    // Return from trap.
    input  logic                 mret,

    // Latched external lines, for mip.
    input  logic [XLEN-1:0]      irq_latched,

    // State seen by the arbiter and the fetch side.
    output logic                 mstatus_mie,
    output logic [XLEN-1:0]      mie_mask,
    output logic [XLEN-1:2]      mtvec,
    output logic [XLEN-1:1]      mepc
);

    // Previous interrupt enable, saved on trap entry.
    logic                 mstatus_mpie;
    logic [XLEN-1:0]      mscratch;
    // mcause split into interrupt flag and number.
    logic                 mcause_int;
    logic [CAUSE_W-1:0]   mcause_no;

    // Assembled read views.
    logic [XLEN-1:0]      mstatus_val;
    logic [XLEN-1:0]      mcause_val;

    always_comb begin
        mstatus_val = '0;
        mstatus_val[MSTATUS_MIE_BIT] = mstatus_mie;
        mstatus_val[MSTATUS_MPIE_BIT] = mstatus_mpie;
    end

    // Interrupt flag in the top bit, number in the low bits.
    assign mcause_val = {mcause_int, {(XLEN-1-CAUSE_W){1'b0}}, mcause_no};

    // Read decode.
    always_comb begin
        csr_exists = 1'b1;
        csr_rdonly = 1'b0;
        csr_rdata = '0;
        case (csr_addr)
            CSR_MSTATUS:   csr_rdata = mstatus_val;
            CSR_MISA:      csr_rdata = MISA_VALUE;
            // No delegation, no upper status bits, no trap value.
            CSR_MEDELEG,
            CSR_MIDELEG,
            CSR_MSTATUSH,
            CSR_MTVAL:     csr_rdata = '0;
            CSR_MIE:       csr_rdata = mie_mask;
            // Direct mode only.
            CSR_MTVEC:     csr_rdata = {mtvec, 2'b00};
            // Pending lines as seen through the enables.
            CSR_MIP:       csr_rdata = irq_latched & mie_mask;
            CSR_MSCRATCH:  csr_rdata = mscratch;
            CSR_MEPC:      csr_rdata = {mepc, 1'b0};
            CSR_MCAUSE:    csr_rdata = mcause_val;
            // ID registers.
            CSR_MVENDORID,
            CSR_MARCHID,
            CSR_MIMPID,
            CSR_MCONFIGPTR: begin
                csr_rdonly = 1'b1;
                csr_rdata = '0;
            end
            CSR_MHARTID: begin
                csr_rdonly = 1'b1;
                csr_rdata = HART_ID;
            end
            default: begin
                csr_exists = 1'b0;
            end
        endcase
    end

    // Update priority is trap entry, then CSR write, then mret.
    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus_mie <= 1'b0;
            mstatus_mpie <= 1'b0;
            mie_mask <= '0;
            mtvec <= '0;
            mscratch <= '0;
            mepc <= '0;
            mcause_int <= 1'b0;
            mcause_no <= '0;
        end else if (ex_take) begin
            // Stack the enable and record where and why.
            mstatus_mpie <= mstatus_mie;
            mstatus_mie <= 1'b0;
            mepc <= ex_epc;
            mcause_int <= ex_irq;
            mcause_no <= ex_cause;
        end else if (csr_we) begin
            case (csr_addr)
                CSR_MSTATUS: begin
                    mstatus_mie <= csr_wdata[MSTATUS_MIE_BIT];
                    mstatus_mpie <= csr_wdata[MSTATUS_MPIE_BIT];
                end
                CSR_MIE:      mie_mask <= csr_wdata;
                CSR_MTVEC:    mtvec <= csr_wdata[XLEN-1:2];
                CSR_MSCRATCH: mscratch <= csr_wdata;
                CSR_MEPC:     mepc <= csr_wdata[XLEN-1:1];
                CSR_MCAUSE: begin
                    mcause_int <= csr_wdata[XLEN-1];
                    mcause_no <= csr_wdata[CAUSE_W-1:0];
                end
                // Read-only or hardwired, write dropped.
                default: begin
                end
            endcase
        end else if (mret) begin
            // Unstack the enable.
            mstatus_mie <= mstatus_mpie;
        end
    end

endmodule

// File: hw/irq_arbiter.sv
// Latches the external interrupt lines, masks them and picks the lowest pending line.
`timescale 1ns/10ps

module irq_arbiter import trap_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    // Raw external lines.
    input  logic [IRQ_HI:IRQ_LO] irq,
    // Per-line enables from mie.
    input  logic [XLEN-1:0]     mie_mask,
    // Global enable from mstatus.
    input  logic                mstatus_mie,
    output logic [XLEN-1:0]     irq_latched,
    output logic                irq_pending,
    output logic [CAUSE_W-1:0]  irq_cause
);

    // Enabled and latched lines.
    logic [XLEN-1:0]      irq_masked;
    // History of mstatus.mie, newest in bit 0.
    logic [MIE_DELAY-1:0] mie_seq;
    // Global enable after the settling delay.
    logic                 irq_en;

    // One cycle of latency on the external lines.
    always_ff @(posedge clk) begin
        if (rst) begin
            irq_latched <= '0;
        end else begin
            irq_latched <= '0;
            irq_latched[IRQ_HI:IRQ_LO] <= irq;
        end
    end

    assign irq_masked = irq_latched & mie_mask;

    // Scan downward so the lowest set line wins.
    always_comb begin
        irq_cause = '0;
        for (int i = IRQ_HI; i >= IRQ_LO; i--) begin
            if (irq_masked[i]) begin
                irq_cause = CAUSE_W'(i);
            end
        end
    end

    // Interrupts stay blocked right after mie goes high.
    always_ff @(posedge clk) begin
        if (rst) begin
            mie_seq <= '0;
        end else begin
            mie_seq <= (mie_seq << 1) | MIE_DELAY'(mstatus_mie);
        end
    end

    assign irq_en = (&mie_seq) && mstatus_mie;
    assign irq_pending = irq_en && (|irq_masked);

endmodule

// File: hw/trap_dispatch.sv
// Chooses between a pending interrupt and a synchronous trap for the retiring instruction.
`timescale 1ns/10ps

module trap_dispatch import trap_pkg::*; (
    // Instruction completing this cycle.
    input  logic                    retire_valid,
    // It raised a synchronous trap.
    input  logic                    retire_trap,
    input  logic [TRAP_CAUSE_W-1:0] retire_cause,

    // From the arbiter.
    input  logic                    irq_pending,
    input  logic [CAUSE_W-1:0]      irq_cause,

    // Trap entry strobe and its cause.
    output logic                    ex_take,
    output logic                    ex_irq,
    output logic [CAUSE_W-1:0]      ex_cause
);

    // Trap cause widened to mcause width.
    logic [CAUSE_W-1:0] trap_cause_ext;

    assign trap_cause_ext = {{(CAUSE_W-TRAP_CAUSE_W){1'b0}}, retire_cause};

    always_comb begin
        ex_take = 1'b0;
        ex_irq = 1'b0;
        ex_cause = '0;
        if (irq_pending && retire_valid) begin
            // Interrupt wins, the trap is dropped with the instruction.
            ex_take = 1'b1;
            ex_irq = 1'b1;
            ex_cause = irq_cause;
        end else if (retire_trap) begin
            // Synchronous trap.
            ex_take = 1'b1;
            ex_cause = trap_cause_ext;
        end
    end

endmodule

// File: hw/trap_unit.sv
// Machine-mode trap and interrupt unit top, instantiated beside the processor pipeline.
`timescale 1ns/10ps

module trap_unit import trap_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    // CSR port.
    input  csr_addr_e               csr_addr,
    input  logic                    csr_we,
    input  logic [XLEN-1:0]         csr_wdata,
    output logic [XLEN-1:0]         csr_rdata,
    output logic                    csr_exists,
    output logic                    csr_rdonly,
    // Retiring instruction.
    input  logic                    retire_valid,
    input  logic                    retire_trap,
    input  logic [TRAP_CAUSE_W-1:0] retire_cause,
    input  logic [XLEN-1:1]         retire_pc,
    input  logic                    mret,
    // External interrupts.
    input  logic [IRQ_HI:IRQ_LO]    irq,
    // Control transfer to the fetch stage.
    output logic                    trap_taken,
    output logic [XLEN-1:2]         trap_vector,
    output logic [XLEN-1:1]         ret_pc
);

    logic                 mstatus_mie;
    logic [XLEN-1:0]      mie_mask;
    logic [XLEN-1:0]      irq_latched;
    logic                 irq_pending;
    logic [CAUSE_W-1:0]   irq_cause;
    logic                 ex_irq;
    logic [CAUSE_W-1:0]   ex_cause;

    // Trap strobe feeds both the CSR update and the fetch redirect.
    csr_file i_csr_file (
        .clk(clk), .rst(rst),
        .csr_addr(csr_addr), .csr_we(csr_we), .csr_wdata(csr_wdata),
        .csr_rdata(csr_rdata), .csr_exists(csr_exists), .csr_rdonly(csr_rdonly),
        .ex_take(trap_taken), .ex_irq(ex_irq), .ex_cause(ex_cause), .ex_epc(retire_pc),
        .mret(mret), .irq_latched(irq_latched),
        .mstatus_mie(mstatus_mie), .mie_mask(mie_mask), .mtvec(trap_vector), .mepc(ret_pc)
    );

    irq_arbiter i_irq_arbiter (
        .clk(clk), .rst(rst), .irq(irq), .mie_mask(mie_mask), .mstatus_mie(mstatus_mie),
        .irq_latched(irq_latched), .irq_pending(irq_pending), .irq_cause(irq_cause)
    );

    trap_dispatch i_trap_dispatch (
        .retire_valid(retire_valid), .retire_trap(retire_trap), .retire_cause(retire_cause),
        .irq_pending(irq_pending), .irq_cause(irq_cause),
        .ex_take(trap_taken), .ex_irq(ex_irq), .ex_cause(ex_cause)
    );

endmodule

// File: test/trap_unit_tasks.svh
// CSR access, retire pulse and bounded wait tasks for inclusion in the trap unit testbench module.

// One-cycle CSR write committed at the rising edge.
task automatic write_csr(input csr_addr_e addr, input logic [XLEN-1:0] data);
    @(negedge clk);
    csr_addr = addr;
    csr_wdata = data;
    csr_we = 1'b1;
    @(negedge clk);
    csr_we = 1'b0;
endtask

// Address held until the next falling edge so the flags stay valid after return.
task automatic read_csr(input csr_addr_e addr, output logic [XLEN-1:0] data);
    @(negedge clk);
    csr_addr = addr;
    csr_we = 1'b0;
    #1;
    data = csr_rdata;
endtask

// Retiring instruction that raises a trap. Trap outputs are sampled in that cycle.
task automatic pulse_retire_trap(input logic [TRAP_CAUSE_W-1:0] cause,
                                 input logic [XLEN-1:1] pc,
                                 output logic taken, output logic [XLEN-1:2] vec);
    @(negedge clk);
    retire_valid = 1'b1;
    retire_trap = 1'b1;
    retire_cause = cause;
    retire_pc = pc;
    #1;
    taken = trap_taken;
    vec = trap_vector;
    @(negedge clk);
    retire_valid = 1'b0;
    retire_trap = 1'b0;
endtask

task automatic pulse_mret();
    @(negedge clk);
    mret = 1'b1;
    @(negedge clk);
    mret = 1'b0;
endtask

task automatic idle_cycles(input int cycles);
    repeat (cycles) @(negedge clk);
endtask

// trap_taken must stay low for the whole window.
task automatic watch_no_trap(input int cycles);
    repeat (cycles) begin
        @(negedge clk);
        #1;
        check_flag("trap_taken", 1'b0, trap_taken);
    end
endtask

// Returns inside the cycle where trap_taken is high.
task automatic wait_for_trap(input int max_cycles, output int waited);
    logic seen;
    seen = 1'b0;
    waited = 0;
    while (!seen && waited < max_cycles) begin
        @(negedge clk);
        #1;
        waited++;
        seen = trap_taken;
    end
    if (!seen) begin
        abort_run($sformatf("Timed out after %0d cycles waiting for trap_taken", max_cycles));
    end
endtask

// File: test/trap_unit_tb.sv
// Self-checking testbench for the trap unit that runs as top module trap_unit_tb.
`timescale 1ns/10ps

module trap_unit_tb import trap_pkg::*; ();

    logic                    clk = 1'b0;
    logic                    rst;
    csr_addr_e               csr_addr;
    logic                    csr_we;
    logic [XLEN-1:0]         csr_wdata;
    logic [XLEN-1:0]         csr_rdata;
    logic                    csr_exists;
    logic                    csr_rdonly;
    logic                    retire_valid;
    logic                    retire_trap;
    logic [TRAP_CAUSE_W-1:0] retire_cause;
    logic [XLEN-1:1]         retire_pc;
    logic                    mret;
    logic [IRQ_HI:IRQ_LO]    irq;
    logic                    trap_taken;
    logic [XLEN-1:2]         trap_vector;
    logic [XLEN-1:1]         ret_pc;

    // Random stimulus state.
    integer seed = 38;

    // 8 ns period.
    always #4 clk = ~clk;

    trap_unit i_dut (
        .clk(clk), .rst(rst),
        .csr_addr(csr_addr), .csr_we(csr_we), .csr_wdata(csr_wdata),
        .csr_rdata(csr_rdata), .csr_exists(csr_exists), .csr_rdonly(csr_rdonly),
        .retire_valid(retire_valid), .retire_trap(retire_trap),
        .retire_cause(retire_cause), .retire_pc(retire_pc), .mret(mret), .irq(irq),
        .trap_taken(trap_taken), .trap_vector(trap_vector), .ret_pc(ret_pc)
    );

    // Report the reason and end the run.
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [XLEN-1:0] expected,
                               input logic [XLEN-1:0] actual);
        assert (actual === expected)
            else abort_run($sformatf("[FAIL] %0t %s expected %h actual %h",
                                     $time, name, expected, actual));
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        assert (actual === expected)
            else abort_run($sformatf("[FAIL] %0t %s expected %b actual %b",
                                     $time, name, expected, actual));
    endtask

    // Read one CSR and compare.
    task automatic expect_csr(input string name, input csr_addr_e addr,
                              input logic [XLEN-1:0] expected);
        logic [XLEN-1:0] data;
        read_csr(addr, data);
        check_value(name, expected, data);
    endtask

    `include "trap_unit_tasks.svh"

    // Reset must hold off any trap.
    assert property (@(posedge clk) rst |-> !trap_taken)
        else abort_run($sformatf("[FAIL] %0t trap_taken expected 0 actual 1 during reset",
                                 $time));
    // Trap entry needs a retiring instruction or a synchronous trap.
    assert property (@(posedge clk) disable iff (rst) trap_taken |-> (retire_valid || retire_trap))
        else abort_run($sformatf("[FAIL] %0t trap_taken expected 0 actual 1 without retire",
                                 $time));

    initial begin
        logic [XLEN-1:0]         rnd;
        logic [XLEN-1:0]         mtvec_val;
        logic [XLEN-1:1]         trap_pc;
        logic [TRAP_CAUSE_W-1:0] cause;
        logic                    taken;
        logic [XLEN-1:2]         vec;
        int                      waited;

        rst = 1'b1;
        csr_addr = CSR_MSTATUS;
        csr_we = 1'b0;
        csr_wdata = '0;
        // Pending lines and a retiring instruction across reset.
        retire_valid = 1'b1;
        retire_trap = 1'b0;
        retire_cause = '0;
        retire_pc = '0;
        mret = 1'b0;
        irq = '1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // No trap while mstatus.mie and mie are still clear.
        watch_no_trap(4);
        @(negedge clk);
        retire_valid = 1'b0;
        irq = '0;

        // Reset values and constant registers.
        expect_csr("mstatus", CSR_MSTATUS, '0);
        expect_csr("mie", CSR_MIE, '0);
        expect_csr("mepc", CSR_MEPC, '0);
        expect_csr("mcause", CSR_MCAUSE, '0);
        expect_csr("misa", CSR_MISA, MISA_VALUE);
        expect_csr("mhartid", CSR_MHARTID, HART_ID);
        check_flag("csr_rdonly", 1'b1, csr_rdonly);

        // Plain read and write.
        rnd = $random(seed);
        write_csr(CSR_MSCRATCH, rnd);
        expect_csr("mscratch", CSR_MSCRATCH, rnd);
        rnd = $random(seed);
        write_csr(CSR_MIE, rnd);
        expect_csr("mie", CSR_MIE, rnd);
        mtvec_val = $random(seed);
        write_csr(CSR_MTVEC, mtvec_val);
        expect_csr("mtvec", CSR_MTVEC, mtvec_val & ~32'h3);
        rnd = $random(seed);
        write_csr(CSR_MEPC, rnd);
        expect_csr("mepc", CSR_MEPC, rnd & ~32'h1);
        // Custom CSR space is not implemented.
        read_csr(csr_addr_e'(12'h7c0), rnd);
        check_flag("csr_exists", 1'b0, csr_exists);
        check_value("csr_rdata", '0, rnd);

        // Synchronous trap with interrupts enabled.
        write_csr(CSR_MSTATUS, 32'h1 << MSTATUS_MIE_BIT);
        rnd = $random(seed);
        cause = rnd[TRAP_CAUSE_W-1:0];
        rnd = $random(seed);
        trap_pc = rnd[XLEN-1:1];
        pulse_retire_trap(cause, trap_pc, taken, vec);
        check_flag("trap_taken", 1'b1, taken);
        check_value("trap_vector", mtvec_val & ~32'h3, {vec, 2'b00});
        expect_csr("mepc", CSR_MEPC, {trap_pc, 1'b0});
        expect_csr("mcause", CSR_MCAUSE, 32'(cause));
        expect_csr("mstatus", CSR_MSTATUS, 32'h1 << MSTATUS_MPIE_BIT);

        // Return restores mie and leaves mpie set.
        pulse_mret();
        expect_csr("mstatus", CSR_MSTATUS,
                   (32'h1 << MSTATUS_MPIE_BIT) | (32'h1 << MSTATUS_MIE_BIT));
        check_value("ret_pc", {trap_pc, 1'b0}, {ret_pc, 1'b0});

        // Lines 20 and 25 pending with the global enable off.
        write_csr(CSR_MSTATUS, '0);
        write_csr(CSR_MIE, (32'h1 << 20) | (32'h1 << 25));
        @(negedge clk);
        irq[20] = 1'b1;
        irq[25] = 1'b1;
        retire_valid = 1'b1;
        watch_no_trap(8);
        expect_csr("mip", CSR_MIP, (32'h1 << 20) | (32'h1 << 25));
        // Enable and expect the lower line after the settling delay.
        write_csr(CSR_MSTATUS, 32'h1 << MSTATUS_MIE_BIT);
        wait_for_trap(20, waited);
        check_flag("early_irq", 1'b1, waited >= MIE_DELAY);
        @(negedge clk);
        retire_valid = 1'b0;
        irq = '0;
        expect_csr("mcause", CSR_MCAUSE, 32'h8000_0000 | 32'd20);

        // Interrupt on line 25 against a synchronous trap.
        @(negedge clk);
        irq[25] = 1'b1;
        write_csr(CSR_MSTATUS, 32'h1 << MSTATUS_MIE_BIT);
        idle_cycles(MIE_DELAY + 1);
        rnd = $random(seed);
        cause = rnd[TRAP_CAUSE_W-1:0];
        rnd = $random(seed);
        trap_pc = rnd[XLEN-1:1];
        pulse_retire_trap(cause, trap_pc, taken, vec);
        check_flag("trap_taken", 1'b1, taken);
        expect_csr("mcause", CSR_MCAUSE, 32'h8000_0000 | 32'd25);
        expect_csr("mepc", CSR_MEPC, {trap_pc, 1'b0});
        @(negedge clk);
        irq = '0;

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: build.f
+incdir+test
hw/trap_pkg.sv
hw/csr_file.sv
hw/irq_arbiter.sv
hw/trap_dispatch.sv
hw/trap_unit.sv
test/trap_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module trap_unit_tb -f build.f \
    -o trap_unit_sim > sim.log 2>&1 &&
./obj_dir/trap_unit_sim >> sim.log 2>&1 ||
echo "Build or run returned an error status" >> sim.log
cat sim.log
grep -q "Simulation completed successfully" sim.log && exit 0 || exit 1
